//--- common/rio_tx_macros.svh
`ifndef RIO_TX_MACROS_SVH
`define RIO_TX_MACROS_SVH

// ------------------------------------------------------------
// Lane support
// ------------------------------------------------------------

// Set to 0 to build without the 2-lane or 4-lane mode
`define SUPPORT_2X 1
`define SUPPORT_4X 1

// Physical lanes on the transceiver side
`define LSIZE ((`SUPPORT_4X) ? 4 : ((`SUPPORT_2X) ? 2 : 1))

// ------------------------------------------------------------
// Link bring-up and idle characters
// ------------------------------------------------------------

// Idle columns sent before the link layer may send data
`define SYNC_COLUMNS 16

// K28.5, K28.3 and K28.0 before 8b/10b encoding
`define CHAR_K 8'hBC
`define CHAR_A 8'h7C
`define CHAR_R 8'h1C

`endif

//--- common/rio_tx_pkg.sv
package rio_tx_pkg;

  // ------------------------------------------------------------
  // Character and lane widths
  // ------------------------------------------------------------

  // One code group ahead of the transceiver 8b/10b encoder
  typedef logic [7:0] char_t;

  // Four characters per lane
  // Most significant byte leaves the lane first
  typedef logic [31:0] lane_word_t;

  // One control flag per byte of the lane word
  // Bit k flags byte k
  typedef logic [3:0] lane_flag_t;

  // ------------------------------------------------------------
  // Column widths
  // ------------------------------------------------------------

  // Whole column ordered {lane 3, lane 2, lane 1, lane 0}
  typedef logic [127:0] column_data_t;

  // Flags for the whole column in the same lane order
  typedef logic [15:0] column_flag_t;

  // One enable bit per physical lane
  typedef logic [3:0] lane_mask_t;

  // Requested lane width from the link layer
  typedef logic [1:0] lane_mode_t;

  localparam lane_mode_t MODE_1X = 2'd0;
  localparam lane_mode_t MODE_2X = 2'd1;
  localparam lane_mode_t MODE_4X = 2'd2;

  // ------------------------------------------------------------
  // Link bring-up FSM
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    LINK_DISABLED,
    LINK_SYNC,
    LINK_ACTIVE
  } link_state_t;

endpackage

//--- source/tx_lane_ctrl.sv
`timescale 1ns/100ps
`include "rio_tx_macros.svh"

module tx_lane_ctrl
  import rio_tx_pkg::*;
(
  input  logic       tx_clk,
  input  logic       rst,
  input  logic       link_enable,
  input  logic       tx_valid,
  input  lane_mode_t lane_mode,
  output logic       tx_ready,
  output logic       link_active,
  output logic       sel_data,
  output logic       sel_idle,
  output logic       idle_start,
  output lane_mask_t lane_en
);

  // Counter wide enough to reach the last sync column
  localparam int CNT_W = $clog2(`SYNC_COLUMNS + 1);

  // Fallback for a lane mode that the build cannot do
  localparam lane_mode_t WIDEST_MODE = (`SUPPORT_4X) ? MODE_4X :
                                       ((`SUPPORT_2X) ? MODE_2X : MODE_1X);

  link_state_t      state;
  link_state_t      state_next;
  logic [CNT_W-1:0] sync_cnt;
  logic             sync_done;
  lane_mode_t       mode_eff;

  // ------------------------------------------------------------
  // Link state machine
  // ------------------------------------------------------------

  // High in the last of the sync cycles
  assign sync_done = (sync_cnt == CNT_W'(`SYNC_COLUMNS - 1));

  always_comb begin
    state_next = state;
    case (state)
      LINK_DISABLED: begin
        if (link_enable) state_next = LINK_SYNC;
      end
      LINK_SYNC: begin
        if (!link_enable) state_next = LINK_DISABLED;
        else if (sync_done) state_next = LINK_ACTIVE;
      end
      LINK_ACTIVE: begin
        if (!link_enable) state_next = LINK_DISABLED;
      end
      default: state_next = LINK_DISABLED;
    endcase
  end

  always_ff @(posedge tx_clk) begin
    if (rst) begin
      state       <= LINK_DISABLED;
      sync_cnt    <= '0;
      tx_ready    <= 1'b0;
      link_active <= 1'b0;
      idle_start  <= 1'b0;
    end else begin
      state       <= state_next;
      tx_ready    <= (state_next == LINK_ACTIVE);
      link_active <= (state_next == LINK_ACTIVE);
      // One cycle pulse in the first sync cycle
      idle_start  <= (state == LINK_DISABLED) && (state_next == LINK_SYNC);
      // Counts sync cycles and clears in every other state
      if (state == LINK_SYNC) sync_cnt <= sync_cnt + 1'b1;
      else sync_cnt <= '0;
    end
  end

  // ------------------------------------------------------------
  // Column source select
  // ------------------------------------------------------------

  // A falling link_enable zeroes the column at that same edge
  always_comb begin
    sel_data = 1'b0;
    sel_idle = 1'b0;
    if (link_enable) begin
      if (tx_ready) begin
        sel_data = tx_valid;
        sel_idle = !tx_valid;
      end else if (state == LINK_SYNC) begin
        sel_idle = 1'b1;
      end
    end
  end

  // Unsupported requests fall back to the widest built mode
  always_comb begin
    mode_eff = lane_mode;
    if ((lane_mode == 2'd3) ||
        ((lane_mode == MODE_4X) && !(`SUPPORT_4X)) ||
        ((lane_mode == MODE_2X) && !(`SUPPORT_2X)))
      mode_eff = WIDEST_MODE;
  end

  always_comb begin
    case (mode_eff)
      MODE_4X: lane_en = 4'b1111;
      MODE_2X: lane_en = 4'b0011;
      default: lane_en = 4'b0001;
    endcase
  end

  // Data is only offered once a full sync run has finished
  a_ready_active: assert property (@(posedge tx_clk) disable iff (rst)
    $rose(tx_ready) |-> (state == LINK_ACTIVE) &&
      $past(state == LINK_SYNC, `SYNC_COLUMNS) &&
      !$past(state == LINK_SYNC, `SYNC_COLUMNS + 1));

  // Exactly one source feeds the mux while the link is up
  a_sel_exclusive: assert property (@(posedge tx_clk) disable iff (rst)
    (link_enable && (state != LINK_DISABLED)) |-> (sel_data ^ sel_idle));

endmodule

//--- source/tx_idle_gen.sv
`timescale 1ns/100ps
`include "rio_tx_macros.svh"

module tx_idle_gen
  import rio_tx_pkg::*;
(
  input  logic         tx_clk,
  input  logic         rst,
  input  logic         idle_start,
  output column_data_t idle_data,
  output column_flag_t idle_datak
);

  localparam logic [6:0] LFSR_SEED = 7'h7F;

  logic [6:0] lfsr;
  logic [6:0] lfsr_next;
  lane_word_t idle_word;

  // Two LFSR bits choose one of the three idle codes
  // K is the more frequent pick
  function automatic char_t pick_char(input logic [1:0] sel);
    char_t code;
    case (sel)
      2'd1:    code = `CHAR_A;
      2'd2:    code = `CHAR_R;
      default: code = `CHAR_K;
    endcase
    return code;
  endfunction

  // ------------------------------------------------------------
  // Four LFSR steps per column
  // ------------------------------------------------------------

  // Polynomial x^7 + x^6 + 1 with slot 0 on the MSB byte
  always_comb begin
    lfsr_next = lfsr;
    idle_word = '0;
    for (int s = 0; s < 4; s++) begin
      lfsr_next = {lfsr_next[5:0], lfsr_next[6] ^ lfsr_next[5]};
      idle_word[8*(3-s) +: 8] = pick_char(lfsr_next[1:0]);
    end
    // First sync column is all K
    if (idle_start) idle_word = {4{`CHAR_K}};
  end

  // Sync entry restarts the sequence from the seed
  always_ff @(posedge tx_clk) begin
    if (rst || idle_start) begin
      lfsr <= LFSR_SEED;
    end else begin
      lfsr <= lfsr_next;
    end
  end

  // ------------------------------------------------------------
  // Column outputs
  // ------------------------------------------------------------

  // Same characters on every lane
  assign idle_data  = {4{idle_word}};
  // Idles are all control characters
  assign idle_datak = '1;

endmodule

//--- source/tx_column_mux.sv
`timescale 1ns/100ps

module tx_column_mux
  import rio_tx_pkg::*;
(
  input  logic         tx_clk,
  input  logic         rst,
  input  column_data_t tx_data,
  input  column_flag_t tx_datak,
  input  column_data_t idle_data,
  input  column_flag_t idle_datak,
  input  logic         sel_data,
  input  logic         sel_idle,
  input  lane_mask_t   lane_en,
  output column_data_t col_data,
  output column_flag_t col_datak
);

  column_data_t data_next;
  column_flag_t datak_next;

  // ------------------------------------------------------------
  // Source select and lane blanking
  // ------------------------------------------------------------

  // Zero column when neither source is selected
  always_comb begin
    data_next  = '0;
    datak_next = '0;
    if (sel_data) begin
      data_next  = tx_data;
      datak_next = tx_datak;
    end else if (sel_idle) begin
      data_next  = idle_data;
      datak_next = idle_datak;
    end
    // Lanes outside the lane mode carry nothing
    for (int i = 0; i < 4; i++) begin
      if (!lane_en[i]) begin
        data_next[32*i +: 32] = '0;
        datak_next[4*i +: 4]  = '0;
      end
    end
  end

  // ------------------------------------------------------------
  // Column register
  // ------------------------------------------------------------

  // Cleared so the transceiver sees zeros out of reset
  always_ff @(posedge tx_clk) begin
    if (rst) begin
      col_data  <= '0;
      col_datak <= '0;
    end else begin
      col_data  <= data_next;
      col_datak <= datak_next;
    end
  end

  // Lane disabled at the sampling edge holds zero one cycle later
  for (genvar g = 0; g < 4; g++) begin : g_lane_chk
    a_lane_off_zero: assert property (@(posedge tx_clk) disable iff (rst)
      !$past(lane_en[g]) |->
        ((col_data[32*g +: 32] == '0) && (col_datak[4*g +: 4] == '0)));
  end

endmodule

//--- source/tx_data_map.sv
`timescale 1ns/100ps
`include "rio_tx_macros.svh"

module tx_data_map
  import rio_tx_pkg::*;
(
  input  column_data_t              col_data,
  input  column_flag_t              col_datak,
  output logic [(`LSIZE*44)-1:0]    tx_phy_data
);

  // ------------------------------------------------------------
  // Transceiver 11-bit field per character
  // ------------------------------------------------------------
  // Bits 7..0 carry the character
  // Bit 8 flags a control character
  // Bit 9 is force disparity and bit 10 the disparity value
  // Both disparity bits stay zero so the encoder runs freely

  // Lanes above the physical lane count are dropped
  for (genvar i = 0; i < `LSIZE; i++) begin : g_lane
    lane_word_t lane_word;
    lane_flag_t lane_flag;

    assign lane_word = col_data[32*i +: 32];
    assign lane_flag = col_datak[4*i +: 4];

    // Slot 0 is the first character on the wire
    // so it takes the most significant byte
    for (genvar j = 0; j < 4; j++) begin : g_slot
      assign tx_phy_data[44*i + 11*j +: 11] =
        {2'b00, lane_flag[3-j], lane_word[8*(3-j) +: 8]};
    end
  end

endmodule

//--- source/rio_tx_top.sv
`timescale 1ns/100ps
`include "rio_tx_macros.svh"

module rio_tx_top
  import rio_tx_pkg::*;
(
  input  logic                       tx_clk,
  input  logic                       rst,
  input  column_data_t               tx_data,
  input  column_flag_t               tx_datak,
  input  logic                       tx_valid,
  input  logic                       link_enable,
  input  lane_mode_t                 lane_mode,
  output logic                       tx_ready,
  output logic                       link_active,
  output logic [(`LSIZE*44)-1:0]     tx_phy_data
);

  logic         sel_data;
  logic         sel_idle;
  logic         idle_start;
  lane_mask_t   lane_en;
  column_data_t idle_data;
  column_flag_t idle_datak;
  column_data_t col_data;
  column_flag_t col_datak;

  // ------------------------------------------------------------
  // Link control
  // ------------------------------------------------------------
  tx_lane_ctrl u_ctrl (
    .tx_clk      (tx_clk),
    .rst         (rst),
    .link_enable (link_enable),
    .tx_valid    (tx_valid),
    .lane_mode   (lane_mode),
    .tx_ready    (tx_ready),
    .link_active (link_active),
    .sel_data    (sel_data),
    .sel_idle    (sel_idle),
    .idle_start  (idle_start),
    .lane_en     (lane_en)
  );

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  tx_idle_gen u_idle (
    .tx_clk     (tx_clk),
    .rst        (rst),
    .idle_start (idle_start),
    .idle_data  (idle_data),
    .idle_datak (idle_datak)
  );

  // Only register stage between the link layer and the transceiver
  tx_column_mux u_mux (
    .tx_clk     (tx_clk),
    .rst        (rst),
    .tx_data    (tx_data),
    .tx_datak   (tx_datak),
    .idle_data  (idle_data),
    .idle_datak (idle_datak),
    .sel_data   (sel_data),
    .sel_idle   (sel_idle),
    .lane_en    (lane_en),
    .col_data   (col_data),
    .col_datak  (col_datak)
  );

  tx_data_map u_map (
    .col_data    (col_data),
    .col_datak   (col_datak),
    .tx_phy_data (tx_phy_data)
  );

endmodule

//--- bench/tb_rio_tx.sv
`timescale 1ns/100ps
`include "rio_tx_macros.svh"

module tb_rio_tx
  import rio_tx_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int PHY_W = `LSIZE * 44;
  // Upper bound of all test lengths in clock cycles
  localparam int TEST_CYCLES = 10 + 2 * (`SYNC_COLUMNS + 12) + 64 + 2 * 64 + 2 * (2 * 16);

  typedef logic [PHY_W-1:0] phy_t;

  logic         tx_clk;
  logic         rst;
  column_data_t tx_data;
  column_flag_t tx_datak;
  logic         tx_valid;
  logic         link_enable;
  lane_mode_t   lane_mode;
  logic         tx_ready;
  logic         link_active;
  phy_t         tx_phy_data;

  integer seed = 32'hd298c4aa;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  rio_tx_top uut (
    .tx_clk      (tx_clk),
    .rst         (rst),
    .tx_data     (tx_data),
    .tx_datak    (tx_datak),
    .tx_valid    (tx_valid),
    .link_enable (link_enable),
    .lane_mode   (lane_mode),
    .tx_ready    (tx_ready),
    .link_active (link_active),
    .tx_phy_data (tx_phy_data)
  );

  initial begin
    tx_clk = 1'b0;
    forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;
  end

  // ------------------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------------------

  // Expected transceiver word with the MSB byte in slot 0 and zeros above the used lanes
  function automatic phy_t model_phy(input column_data_t d, input column_flag_t k,
                                     input int lanes);
    phy_t        exp_phy;
    logic [7:0]  ch;
    logic        fl;
    exp_phy = '0;
    for (int i = 0; i < lanes; i++) begin
      for (int j = 0; j < 4; j++) begin
        ch = d[32*i + 24 - 8*j +: 8];
        fl = k[4*i + 3 - j];
        exp_phy[44*i + 11*j +: 11] = {2'b00, fl, ch};
      end
    end
    return exp_phy;
  endfunction

  // Checks for an idle column with flagged K, A or R fields and equal enabled lanes
  function automatic bit idle_ok(input phy_t p, input int lanes, input bit first);
    logic [10:0] f;
    bit          ok;
    ok = 1'b1;
    for (int i = 0; i < `LSIZE; i++) begin
      for (int j = 0; j < 4; j++) begin
        f = p[44*i + 11*j +: 11];
        if (i >= lanes) begin
          if (f != 11'h000) ok = 1'b0;
        end else begin
          if (f[10:8] != 3'b001) ok = 1'b0;
          if (f[7:0] != `CHAR_K && f[7:0] != `CHAR_A && f[7:0] != `CHAR_R) ok = 1'b0;
          if (first && f[7:0] != `CHAR_K) ok = 1'b0;
          if (f != p[11*j +: 11]) ok = 1'b0;
        end
      end
    end
    return ok;
  endfunction

  // Force disparity and disparity value of every field
  function automatic bit disparity_clear(input phy_t p);
    bit ok;
    ok = 1'b1;
    for (int n = 0; n < 4 * `LSIZE; n++) begin
      if (p[11*n + 9 +: 2] != 2'b00) ok = 1'b0;
    end
    return ok;
  endfunction

  task automatic next_cycle;
    @(posedge tx_clk);
    #1;
  endtask

  task automatic compare_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_phy(input phy_t got, input phy_t exp);
    if (got !== exp) begin
      $display("FAILED tx_phy_data: got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic random_column(output column_data_t d, output column_flag_t k);
    d = {$random(seed), $random(seed), $random(seed), $random(seed)};
    k = 16'($random(seed));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // Shared sequences
  // ------------------------------------------------------------

  // Called right after link_enable rises with tx_valid low
  task automatic check_sync_run;
    int cols;
    int waited;
    cols = 0;
    waited = 0;
    next_cycle();
    while (tx_phy_data == '0 && waited < 8) begin
      next_cycle();
      waited++;
    end
    if (tx_phy_data == '0) begin
      $display("no sync column seen within 8 cycles of link_enable rising");
      errors++;
      return;
    end
    // First sync column is all K
    if (!idle_ok(tx_phy_data, `LSIZE, 1'b1)) begin
      $display("first sync column is not all K: tx_phy_data = %h", tx_phy_data);
      errors++;
    end
    cols = 1;
    while (!tx_ready && cols < `SYNC_COLUMNS + 4) begin
      compare_level("link_active", link_active, 1'b0);
      next_cycle();
      cols++;
      if (!idle_ok(tx_phy_data, `LSIZE, 1'b0)) begin
        $display("sync column %0d is not a valid idle: tx_phy_data = %h", cols, tx_phy_data);
        errors++;
      end
    end
    // tx_ready shows up together with the last sync column
    if (cols != `SYNC_COLUMNS) begin
      $display("FAILED sync column count: got %h expected %h", cols, `SYNC_COLUMNS);
      errors++;
    end
    compare_level("tx_ready", tx_ready, 1'b1);
    compare_level("link_active", link_active, 1'b1);
  endtask

  // Each driven column is checked right after its accepting edge
  task automatic stream_columns(input int count, input int lanes, input bit gaps);
    column_data_t d;
    column_flag_t k;
    phy_t         exp_q[$];
    int           sent;
    int           guard;
    bit           gap;
    sent = 0;
    guard = 0;
    while (sent < count && guard < 4 * count) begin
      compare_level("tx_ready", tx_ready, 1'b1);
      gap = gaps && (($random(seed) & 3) == 0);
      if (gap) begin
        tx_valid = 1'b0;
      end else begin
        random_column(d, k);
        tx_data  = d;
        tx_datak = k;
        tx_valid = 1'b1;
        exp_q.push_back(model_phy(d, k, lanes));
        sent++;
      end
      next_cycle();
      guard++;
      if (gap) begin
        if (!idle_ok(tx_phy_data, lanes, 1'b0)) begin
          $display("gap cycle shows no valid idle: tx_phy_data = %h", tx_phy_data);
          errors++;
        end
      end else begin
        compare_phy(tx_phy_data, exp_q.pop_front());
      end
      if (!disparity_clear(tx_phy_data)) begin
        $display("disparity bits set in tx_phy_data = %h", tx_phy_data);
        errors++;
      end
    end
    tx_valid = 1'b0;
    if (sent != count) begin
      $display("stream gave up after %0d cycles with %0d of %0d sent", guard, sent, count);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  // Data offered while disabled must never leak out
  task automatic test_reset_quiet;
    int           e0;
    column_data_t d;
    column_flag_t k;
    e0 = errors;
    for (int c = 0; c < 8; c++) begin
      compare_level("tx_ready", tx_ready, 1'b0);
      compare_level("link_active", link_active, 1'b0);
      compare_phy(tx_phy_data, '0);
      random_column(d, k);
      tx_data  = d;
      tx_datak = k;
      tx_valid = 1'b1;
      next_cycle();
    end
    tx_valid = 1'b0;
    finish_test("reset_quiet", e0);
  endtask

  task automatic test_sync;
    int e0;
    e0 = errors;
    lane_mode   = MODE_4X;
    link_enable = 1'b1;
    check_sync_run();
    finish_test("sync", e0);
  endtask

  task automatic test_full_rate;
    int e0;
    e0 = errors;
    stream_columns(64, `LSIZE, 1'b0);
    finish_test("full_rate", e0);
  endtask

  task automatic test_gaps;
    int e0;
    e0 = errors;
    stream_columns(64, `LSIZE, 1'b1);
    finish_test("gaps", e0);
  endtask

  task automatic test_lane_modes;
    int e0;
    e0 = errors;
    lane_mode = MODE_1X;
    stream_columns(16, 1, 1'b1);
    lane_mode = MODE_2X;
    stream_columns(16, 2, 1'b1);
    lane_mode = MODE_4X;
    finish_test("lane_modes", e0);
  endtask

  // Drop with a column on offer, then a second bring-up
  task automatic test_link_drop;
    int           e0;
    column_data_t d;
    column_flag_t k;
    e0 = errors;
    random_column(d, k);
    tx_data     = d;
    tx_datak    = k;
    tx_valid    = 1'b1;
    link_enable = 1'b0;
    for (int c = 0; c < 3; c++) begin
      next_cycle();
      compare_phy(tx_phy_data, '0);
      compare_level("tx_ready", tx_ready, 1'b0);
      compare_level("link_active", link_active, 1'b0);
    end
    tx_valid    = 1'b0;
    link_enable = 1'b1;
    check_sync_run();
    finish_test("link_drop", e0);
  endtask

  // ------------------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    rst         = 1'b1;
    tx_data     = '0;
    tx_datak    = '0;
    tx_valid    = 1'b0;
    link_enable = 1'b0;
    lane_mode   = MODE_4X;
    repeat (2) @(posedge tx_clk);
    #1;
    rst = 1'b0;
    test_reset_quiet();
    test_sync();
    test_full_rate();
    test_gaps();
    test_lane_modes();
    test_link_drop();
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", 2 * TEST_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- flist.f
+incdir+common
common/rio_tx_pkg.sv
source/tx_lane_ctrl.sv
source/tx_idle_gen.sv
source/tx_column_mux.sv
source/tx_data_map.sv
source/rio_tx_top.sv
bench/tb_rio_tx.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat flist.f)) common/rio_tx_macros.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_rio_tx: flist.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_rio_tx -o Vtb_rio_tx

run: obj_dir/Vtb_rio_tx
	./obj_dir/Vtb_rio_tx | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
